// File: all.f
+incdir+.
read_pipe_pkg.sv
rdyack_fifo.sv
chunk_head.sv
chunk_fetch.sv
chunk_buffer.sv
chunk_readout.sv
read_pipeline.sv
read_pipeline_checker.sv
read_pipeline_monitor.sv
tb_read_pipeline.sv

// File: chunk_buffer.sv
// on-chip chunk buffer, one word slice per slot
// single write port from the fetch stage, registered read for readout
`timescale 1ns/1ps
`include "read_pipe_defines.svh"

module chunk_buffer
	import read_pipe_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_wr_en,
	input  buf_wr_t                i_wr,
	input  logic [`RP_SLOT_BW-1:0] i_rd_slot,
	input  word_idx_t              i_rd_word,
	output logic [`RP_WORD_BW-1:0] o_rd_data
);

	localparam int DEPTH = `RP_N_SLOT * `RP_CHUNK_MAX;

	logic [`RP_WORD_BW-1:0]   mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_idx;
	logic [$clog2(DEPTH)-1:0] rd_idx;

	// slot in the high bits, word in the low bits
	assign wr_idx = {i_wr.slot, i_wr.word};
	assign rd_idx = {i_rd_slot, i_rd_word};

	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[wr_idx] <= i_wr.data;
		end
	end

	// read every cycle, data follows the address by one cycle
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_rd_data <= '0;
		end else begin
			o_rd_data <= mem[rd_idx];
		end
	end

endmodule

// File: chunk_fetch.sv
// execute stage of the read pipeline
// allocates a buffer slot per descriptor, issues one memory read address
// per word, and writes the returning words into the slot in order
// a finished slot is pushed to the done queue as a fill tag
`timescale 1ns/1ps
`include "read_pipe_defines.svh"

module chunk_fetch
	import read_pipe_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_desc_rdy,
	output logic                   o_desc_ack,
	input  chunk_desc_t            i_desc,
	output logic                   o_dramra_rdy,
	input  logic                   i_dramra_ack,
	output logic [`RP_ADDR_BW-1:0] o_dramra,
	input  logic                   i_dramrd_rdy,
	output logic                   o_dramrd_ack,
	input  logic [`RP_WORD_BW-1:0] i_dramrd,
	output logic                   o_wr_en,
	output buf_wr_t                o_wr,
	output logic                   o_done_rdy,
	input  logic                   i_done_ack,
	output fill_tag_t              o_done,
	input  logic                   i_free
);

	// allocator
	logic [`RP_SLOT_BW:0]   n_busy;
	logic [`RP_SLOT_BW-1:0] alloc_slot;
	logic                   slot_free;
	// address looper
	logic [`RP_LEN_BW-1:0]  ra_left;
	logic                   ra_xfer;
	logic                   ra_last;
	logic                   looper_free;
	logic                   desc_take;
	// pending fill tags
	fill_tag_t              new_tag;
	fill_tag_t              pend_tag;
	logic                   pend_src_ack;
	logic                   pend_dst_rdy;
	logic                   pend_dst_ack;
	// writer
	logic [`RP_LEN_BW-1:0]  wr_cnt;
	logic                   wr_last;
	logic                   rd_xfer;

	// ======================================================================
	// slot allocation and descriptor intake
	// ======================================================================
	assign slot_free   = (n_busy != `RP_N_SLOT);
	assign ra_xfer     = o_dramra_rdy && i_dramra_ack;
	assign ra_last     = (ra_left == '0);
	// next chunk may start on the cycle the last address goes out
	assign looper_free = !o_dramra_rdy || (i_dramra_ack && ra_last);
	assign desc_take   = looper_free && slot_free;
	assign o_desc_ack  = i_desc_rdy && desc_take && pend_src_ack;

	assign new_tag.slot = alloc_slot;
	assign new_tag.len  = i_desc.len;

	// slots come back in allocation order, so a counter and a
	// round-robin pointer are enough
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			n_busy     <= '0;
			alloc_slot <= '0;
		end else begin
			case ({o_desc_ack, i_free})
				2'b10:   n_busy <= n_busy + 1'b1;
				2'b01:   n_busy <= n_busy - 1'b1;
				default: n_busy <= n_busy;
			endcase
			if (o_desc_ack) begin
				alloc_slot <= (alloc_slot == `RP_N_SLOT - 1) ? '0 : alloc_slot + 1'b1;
			end
		end
	end

	// ======================================================================
	// address looper
	// ======================================================================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_dramra_rdy <= 1'b0;
			ra_left      <= '0;
		end else if (o_desc_ack) begin
			o_dramra_rdy <= 1'b1;
			ra_left      <= i_desc.len - 1'b1;
		end else if (ra_xfer) begin
			if (ra_last) begin
				o_dramra_rdy <= 1'b0;
			end else begin
				ra_left <= ra_left - 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_desc_ack) begin
			o_dramra <= i_desc.start_addr;
		end else if (ra_xfer) begin
			o_dramra <= o_dramra + 1'b1;
		end
	end

	// tags of chunks whose data is still coming back
	rdyack_fifo #(
		.payload_t(fill_tag_t),
		.DEPTH(2)
	) pend_fifo_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_src_rdy(i_desc_rdy && desc_take),
		.o_src_ack(pend_src_ack),
		.i_src(new_tag),
		.o_dst_rdy(pend_dst_rdy),
		.i_dst_ack(pend_dst_ack),
		.o_dst(pend_tag)
	);

	// ======================================================================
	// buffer writer
	// ======================================================================
	assign wr_last = (wr_cnt + 1'b1 == pend_tag.len);
	// last word waits until the done queue can take the tag
	assign o_dramrd_ack = pend_dst_rdy && (!wr_last || i_done_ack);
	assign rd_xfer      = i_dramrd_rdy && o_dramrd_ack;
	assign pend_dst_ack = rd_xfer && wr_last;

	assign o_wr_en   = rd_xfer;
	assign o_wr.slot = pend_tag.slot;
	assign o_wr.word = word_idx_t'(wr_cnt);
	assign o_wr.data = i_dramrd;

	assign o_done_rdy = i_dramrd_rdy && pend_dst_rdy && wr_last;
	assign o_done     = pend_tag;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_cnt <= '0;
		end else if (rd_xfer) begin
			wr_cnt <= wr_last ? '0 : wr_cnt + 1'b1;
		end
	end

endmodule

// File: chunk_head.sv
// decode stage, turns a block request into a chunk descriptor
// start = base + row offset * row stride + column offset
// the descriptor sits in an output register with its own rdy
`timescale 1ns/1ps
`include "read_pipe_defines.svh"

module chunk_head
	import read_pipe_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_req_rdy,
	output logic        o_req_ack,
	input  block_req_t  i_req,
	input  chunk_cfg_t  i_cfg [`RP_N_CFG],
	output logic        o_desc_rdy,
	input  logic        i_desc_ack,
	output chunk_desc_t o_desc
);

	chunk_cfg_t             cfg_sel;
	logic [`RP_ADDR_BW-1:0] row_ofs_ext;
	logic [`RP_ADDR_BW-1:0] col_ofs_ext;
	logic [`RP_ADDR_BW-1:0] start_addr;
	logic                   req_xfer;
	logic                   desc_xfer;

	// ======================================================================
	// address computation
	// ======================================================================
	assign cfg_sel     = i_cfg[i_req.cfg_id];
	assign row_ofs_ext = {{(`RP_ADDR_BW - `RP_OFS_BW){1'b0}}, i_req.row_ofs};
	assign col_ofs_ext = {{(`RP_ADDR_BW - `RP_OFS_BW){1'b0}}, i_req.col_ofs};
	// product wraps to the address width
	assign start_addr  = cfg_sel.base + row_ofs_ext * cfg_sel.row_stride + col_ofs_ext;

	// ======================================================================
	// output register
	// ======================================================================
	// take a request only if the register is empty or drains this cycle
	assign o_req_ack = i_req_rdy && (!o_desc_rdy || i_desc_ack);
	assign req_xfer  = o_req_ack;
	assign desc_xfer = o_desc_rdy && i_desc_ack;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_desc_rdy <= 1'b0;
		end else if (req_xfer) begin
			o_desc_rdy <= 1'b1;
		end else if (desc_xfer) begin
			o_desc_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (req_xfer) begin
			o_desc.start_addr <= start_addr;
			o_desc.len        <= cfg_sel.len;
		end
	end

endmodule

// File: chunk_readout.sv
// result stage, streams one completed slot at a time to the consumer
// first word shows two cycles after the done-queue transfer
// o_free pulses the cycle after the last word is taken
`timescale 1ns/1ps
`include "read_pipe_defines.svh"

module chunk_readout
	import read_pipe_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_done_rdy,
	output logic                   o_done_ack,
	input  fill_tag_t              i_done,
	output logic [`RP_SLOT_BW-1:0] o_rd_slot,
	output word_idx_t              o_rd_word,
	input  logic [`RP_WORD_BW-1:0] i_rd_data,
	output logic                   o_sramrd_rdy,
	input  logic                   i_sramrd_ack,
	output logic [`RP_WORD_BW-1:0] o_sramrd,
	output logic                   o_sramrd_last,
	output logic                   o_free
);

	logic                  busy;
	fill_tag_t             tag;
	logic [`RP_LEN_BW-1:0] out_cnt;
	logic [`RP_LEN_BW-1:0] rd_cnt;
	logic                  out_xfer;
	logic                  out_last;

	assign o_done_ack = i_done_rdy && !busy;
	assign out_xfer   = o_sramrd_rdy && i_sramrd_ack;
	assign out_last   = (out_cnt + 1'b1 == tag.len);

	// read one word ahead on a transfer so the next word is ready next cycle,
	// otherwise keep re-reading the offered word
	assign rd_cnt    = out_xfer ? out_cnt + 1'b1 : out_cnt;
	assign o_rd_slot = tag.slot;
	assign o_rd_word = word_idx_t'(rd_cnt);

	assign o_sramrd      = i_rd_data;
	assign o_sramrd_last = o_sramrd_rdy && out_last;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			busy         <= 1'b0;
			o_sramrd_rdy <= 1'b0;
			out_cnt      <= '0;
			o_free       <= 1'b0;
		end else begin
			o_free <= out_xfer && out_last;
			if (o_done_ack) begin
				busy    <= 1'b1;
				out_cnt <= '0;
			end else if (busy && !o_sramrd_rdy) begin
				// first word read is now in the buffer output register
				o_sramrd_rdy <= 1'b1;
			end else if (out_xfer) begin
				if (out_last) begin
					busy         <= 1'b0;
					o_sramrd_rdy <= 1'b0;
				end else begin
					out_cnt <= out_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_done_ack) begin
			tag <= i_done;
		end
	end

endmodule

// File: rdyack_fifo.sv
// small circular queue with rdy/ack on both sides
// payload type and depth are set per instance
// output rdy follows a push by one cycle, input ack drops while full
`timescale 1ns/1ps

module rdyack_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 2
) (
	input  logic     i_clk,
	input  logic     i_rst,
	input  logic     i_src_rdy,
	output logic     o_src_ack,
	input  payload_t i_src,
	output logic     o_dst_rdy,
	input  logic     i_dst_ack,
	output payload_t o_dst
);

	localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BW = $clog2(DEPTH + 1);

	payload_t          mem [DEPTH];
	logic [PTR_BW-1:0] wr_ptr;
	logic [PTR_BW-1:0] rd_ptr;
	logic [CNT_BW-1:0] count;
	logic              push;
	logic              pop;

	assign o_src_ack = (count != DEPTH);
	assign o_dst_rdy = (count != 0);
	assign o_dst     = mem[rd_ptr];
	assign push      = i_src_rdy && o_src_ack;
	assign pop       = o_dst_rdy && i_dst_ack;

	always_ff @(posedge i_clk) begin
		if (push) begin
			mem[wr_ptr] <= i_src;
		end
	end

	// pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: read_pipe_defines.svh
// widths and sizes shared by the chunk read pipeline
// include this before the package and in any module that sizes a port
`ifndef READ_PIPE_DEFINES_SVH
`define READ_PIPE_DEFINES_SVH

// data and address widths
`define RP_WORD_BW 32
`define RP_ADDR_BW 32
`define RP_OFS_BW 16

// configurations and chunk buffer geometry
`define RP_N_CFG 2
`define RP_N_SLOT 4
`define RP_CHUNK_MAX 8
`define RP_LEN_BW 4
`define RP_SLOT_BW 2

// completed-slot queue between fetch and readout
`define RP_DONE_DEPTH 3

`endif

// File: read_pipe_pkg.sv
// packed payload types passed between the read pipeline stages
// modules pull these in with a wildcard import in their header
`include "read_pipe_defines.svh"

package read_pipe_pkg;

	// word position inside one buffer slot
	typedef logic [$clog2(`RP_CHUNK_MAX)-1:0] word_idx_t;

	// block request, offsets are in rows and words
	typedef struct packed {
		logic [$clog2(`RP_N_CFG)-1:0] cfg_id;
		logic [`RP_OFS_BW-1:0]        row_ofs;
		logic [`RP_OFS_BW-1:0]        col_ofs;
	} block_req_t;

	typedef struct packed {
		logic [`RP_ADDR_BW-1:0] base;
		logic [`RP_ADDR_BW-1:0] row_stride;
		logic [`RP_LEN_BW-1:0]  len;
	} chunk_cfg_t;

	typedef struct packed {
		logic [`RP_ADDR_BW-1:0] start_addr;
		logic [`RP_LEN_BW-1:0]  len;
	} chunk_desc_t;

	// slot being filled, or a filled slot waiting for readout
	typedef struct packed {
		logic [`RP_SLOT_BW-1:0] slot;
		logic [`RP_LEN_BW-1:0]  len;
	} fill_tag_t;

	typedef struct packed {
		logic [`RP_SLOT_BW-1:0] slot;
		word_idx_t              word;
		logic [`RP_WORD_BW-1:0] data;
	} buf_wr_t;

endpackage

// File: read_pipeline.sv
// top of the chunk read pipeline
// request -> head -> descriptor queue -> fetch -> buffer -> done queue -> readout
// configurations are expected to stay static while requests are in flight
`timescale 1ns/1ps
`include "read_pipe_defines.svh"

module read_pipeline
	import read_pipe_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_req_rdy,
	output logic                   o_req_ack,
	input  block_req_t             i_req,
	input  chunk_cfg_t             i_cfg [`RP_N_CFG],
	output logic                   o_dramra_rdy,
	input  logic                   i_dramra_ack,
	output logic [`RP_ADDR_BW-1:0] o_dramra,
	input  logic                   i_dramrd_rdy,
	output logic                   o_dramrd_ack,
	input  logic [`RP_WORD_BW-1:0] i_dramrd,
	output logic                   o_sramrd_rdy,
	input  logic                   i_sramrd_ack,
	output logic [`RP_WORD_BW-1:0] o_sramrd,
	output logic                   o_sramrd_last
);

	// head to descriptor queue
	logic                   head_desc_rdy;
	logic                   head_desc_ack;
	chunk_desc_t            head_desc;
	// descriptor queue to fetch
	logic                   fetch_desc_rdy;
	logic                   fetch_desc_ack;
	chunk_desc_t            fetch_desc;
	// fetch to buffer
	logic                   wr_en;
	buf_wr_t                wr;
	// done queue, both sides
	logic                   done_in_rdy;
	logic                   done_in_ack;
	fill_tag_t              done_in;
	logic                   done_out_rdy;
	logic                   done_out_ack;
	fill_tag_t              done_out;
	// readout to buffer and allocator
	logic [`RP_SLOT_BW-1:0] rd_slot;
	word_idx_t              rd_word;
	logic [`RP_WORD_BW-1:0] rd_data;
	logic                   free;

	chunk_head chunk_head_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_req_rdy(i_req_rdy),
		.o_req_ack(o_req_ack),
		.i_req(i_req),
		.i_cfg(i_cfg),
		.o_desc_rdy(head_desc_rdy),
		.i_desc_ack(head_desc_ack),
		.o_desc(head_desc)
	);

	rdyack_fifo #(
		.payload_t(chunk_desc_t),
		.DEPTH(2)
	) desc_fifo_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_src_rdy(head_desc_rdy),
		.o_src_ack(head_desc_ack),
		.i_src(head_desc),
		.o_dst_rdy(fetch_desc_rdy),
		.i_dst_ack(fetch_desc_ack),
		.o_dst(fetch_desc)
	);

	chunk_fetch chunk_fetch_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_desc_rdy(fetch_desc_rdy),
		.o_desc_ack(fetch_desc_ack),
		.i_desc(fetch_desc),
		.o_dramra_rdy(o_dramra_rdy),
		.i_dramra_ack(i_dramra_ack),
		.o_dramra(o_dramra),
		.i_dramrd_rdy(i_dramrd_rdy),
		.o_dramrd_ack(o_dramrd_ack),
		.i_dramrd(i_dramrd),
		.o_wr_en(wr_en),
		.o_wr(wr),
		.o_done_rdy(done_in_rdy),
		.i_done_ack(done_in_ack),
		.o_done(done_in),
		.i_free(free)
	);

	chunk_buffer chunk_buffer_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_wr_en(wr_en),
		.i_wr(wr),
		.i_rd_slot(rd_slot),
		.i_rd_word(rd_word),
		.o_rd_data(rd_data)
	);

	rdyack_fifo #(
		.payload_t(fill_tag_t),
		.DEPTH(`RP_DONE_DEPTH)
	) done_fifo_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_src_rdy(done_in_rdy),
		.o_src_ack(done_in_ack),
		.i_src(done_in),
		.o_dst_rdy(done_out_rdy),
		.i_dst_ack(done_out_ack),
		.o_dst(done_out)
	);

	chunk_readout chunk_readout_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_done_rdy(done_out_rdy),
		.o_done_ack(done_out_ack),
		.i_done(done_out),
		.o_rd_slot(rd_slot),
		.o_rd_word(rd_word),
		.i_rd_data(rd_data),
		.o_sramrd_rdy(o_sramrd_rdy),
		.i_sramrd_ack(i_sramrd_ack),
		.o_sramrd(o_sramrd),
		.o_sramrd_last(o_sramrd_last),
		.o_free(free)
	);

endmodule

// File: read_pipeline_checker.sv
// concurrent checks bound into the read pipeline top level
// rdy and payload must hold until ack on the address and output ports
// chunks between slot allocation and their last output word never outnumber the slots
`timescale 1ns/1ps
`include "read_pipe_defines.svh"

module read_pipeline_checker (
	input logic                   i_clk,
	input logic                   i_rst,
	input logic                   i_sramrd_rdy,
	input logic                   i_sramrd_ack,
	input logic [`RP_WORD_BW-1:0] i_sramrd,
	input logic                   i_sramrd_last,
	input logic                   i_dramra_rdy,
	input logic                   i_dramra_ack,
	input logic [`RP_ADDR_BW-1:0] i_dramra,
	input logic                   i_alloc
);

	int   n_fail = 0;
	int   n_chunks;
	logic chunk_done;

	// a chunk leaves with the transfer of its last output word
	assign chunk_done = i_sramrd_rdy && i_sramrd_ack && i_sramrd_last;

	// chunks between slot allocation and the end of their readout
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			n_chunks <= 0;
		end else begin
			n_chunks <= n_chunks + int'(i_alloc) - int'(chunk_done);
		end
	end

	sramrd_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_sramrd_rdy && !i_sramrd_ack |=>
			i_sramrd_rdy && $stable(i_sramrd) && $stable(i_sramrd_last))
		else begin
			n_fail++;
			$error("output word withdrawn or changed before ack");
		end

	dramra_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_dramra_rdy && !i_dramra_ack |=> i_dramra_rdy && $stable(i_dramra))
		else begin
			n_fail++;
			$error("memory address withdrawn or changed before ack");
		end

	slot_limit: assert property (@(posedge i_clk) disable iff (!i_rst)
		n_chunks >= 0 && n_chunks <= `RP_N_SLOT)
		else begin
			n_fail++;
			$error("more chunks in flight than buffer slots");
		end

endmodule

// File: read_pipeline_monitor.sv
// testbench monitor for the read pipeline
// checks memory addresses and output words against the expected chunks
// that the testbench top posts through the i_exp_* inputs
`timescale 1ns/1ps
`include "read_pipe_defines.svh"

module read_pipeline_monitor #(
	parameter logic [`RP_WORD_BW-1:0] MEM_SALT = '0
) (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_req_rdy,
	input  logic                   i_req_ack,
	input  logic                   i_dramra_rdy,
	input  logic                   i_dramra_ack,
	input  logic [`RP_ADDR_BW-1:0] i_dramra,
	input  logic                   i_sramrd_rdy,
	input  logic                   i_sramrd_ack,
	input  logic [`RP_WORD_BW-1:0] i_sramrd,
	input  logic                   i_sramrd_last,
	input  logic                   i_exp_valid,
	input  logic [`RP_ADDR_BW-1:0] i_exp_start,
	input  logic [`RP_LEN_BW-1:0]  i_exp_len,
	output int                     o_mismatch_cnt,
	output int                     o_fail_cnt,
	output int                     o_words_out,
	output int                     o_pending
);

	// one queue pair for the address side and one for the output side
	logic [`RP_ADDR_BW-1:0] ra_start [$];
	logic [`RP_LEN_BW-1:0]  ra_len [$];
	logic [`RP_ADDR_BW-1:0] out_start [$];
	logic [`RP_LEN_BW-1:0]  out_len [$];
	int                     ra_idx;
	int                     out_idx;
	logic                   seen_req;
	logic [`RP_WORD_BW-1:0] exp_data;
	logic                   exp_last;

	initial begin
		ra_idx         = 0;
		out_idx        = 0;
		seen_req       = 1'b0;
		o_mismatch_cnt = 0;
		o_fail_cnt     = 0;
		o_words_out    = 0;
		o_pending      = 0;
	end

	// all inputs are sampled at the rising edge before the DUT updates
	always @(posedge i_clk) begin
		if (i_exp_valid) begin
			ra_start.push_back(i_exp_start);
			ra_len.push_back(i_exp_len);
			out_start.push_back(i_exp_start);
			out_len.push_back(i_exp_len);
		end
		if (i_rst) begin
			if (i_req_rdy) begin
				seen_req = 1'b1;
			end
			if (!seen_req && (i_req_ack || i_dramra_rdy || i_sramrd_rdy)) begin
				$display("%0d ns: DUT handshake went high before the first request", $time);
				o_fail_cnt++;
			end

			// memory address side
			if (i_dramra_rdy && i_dramra_ack) begin
				if (ra_start.size() == 0) begin
					$display("%0d ns: memory address %h issued with no chunk expected",
						$time, i_dramra);
					o_fail_cnt++;
				end else begin
					if (i_dramra !== ra_start[0] + ra_idx) begin
						$display("Mismatch at %0d ns: o_dramra got %h expected %h",
							$time, i_dramra, ra_start[0] + ra_idx);
						o_mismatch_cnt++;
					end
					ra_idx++;
					if (ra_idx == ra_len[0]) begin
						void'(ra_start.pop_front());
						void'(ra_len.pop_front());
						ra_idx = 0;
					end
				end
			end

			// output word side
			if (i_sramrd_rdy && i_sramrd_ack) begin
				o_words_out++;
				if (out_start.size() == 0) begin
					$display("%0d ns: output word %h delivered with no chunk expected",
						$time, i_sramrd);
					o_fail_cnt++;
				end else begin
					exp_data = out_start[0] + out_idx + MEM_SALT;
					exp_last = (out_idx == out_len[0] - 1);
					if (i_sramrd !== exp_data) begin
						$display("Mismatch at %0d ns: o_sramrd got %h expected %h",
							$time, i_sramrd, exp_data);
						o_mismatch_cnt++;
					end
					if (i_sramrd_last !== exp_last) begin
						$display("Mismatch at %0d ns: o_sramrd_last got %b expected %b",
							$time, i_sramrd_last, exp_last);
						o_mismatch_cnt++;
					end
					out_idx++;
					if (exp_last) begin
						void'(out_start.pop_front());
						void'(out_len.pop_front());
						out_idx = 0;
					end
				end
			end
		end
		o_pending = ra_start.size() + out_start.size();
	end

endmodule

// File: read_pipeline_vectors.txt
// configurations, one line per id: base row_stride len
// requests: cfg_id row_ofs col_ofs expected_start expected_len
00001000 00000040 00000008
00020000 00000100 00000005
// number of requests that follow
0000000a
0 0000 0000 00001000 8
1 0002 0003 00020203 5
0 0003 0010 000010d0 8
1 0010 0020 00021020 5
0 0100 0005 00005005 8
1 0000 00ff 000200ff 5
0 0001 0000 00001040 8
1 0001 0001 00020101 5
0 0020 0007 00001807 8
1 00ff 0000 0002ff00 5

// File: run.sh
#!/usr/bin/env bash
# build and run the read pipeline testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_read_pipeline -o sim_read_pipeline
./obj_dir/sim_read_pipeline +verilator+error+limit+1000 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// File: tb_read_pipeline.sv
// testbench top for the chunk read pipeline
// configurations and requests come from read_pipeline_vectors.txt
// external memory is modelled with random delays and the monitor compares
`timescale 1ns/1ps
`include "read_pipe_defines.svh"

module tb_read_pipeline
	import read_pipe_pkg::*;
();

	localparam int                     CLK_PERIOD    = 100;
	localparam int                     DRIVE_DELAY   = 1;
	localparam logic [`RP_WORD_BW-1:0] MEM_SALT      = 32'h5a00_0000;
	localparam int                     VEC_WORDS     = 64;
	localparam int                     REQ_TIMEOUT   = 400;
	localparam int                     DRAIN_TIMEOUT = 2000;
	localparam int                     STALL_CYCLES  = 80;

	logic                   i_clk;
	logic                   i_rst;
	logic                   i_req_rdy;
	logic                   o_req_ack;
	block_req_t             i_req;
	chunk_cfg_t             cfg [`RP_N_CFG];
	logic                   o_dramra_rdy;
	logic                   i_dramra_ack;
	logic [`RP_ADDR_BW-1:0] o_dramra;
	logic                   i_dramrd_rdy;
	logic                   o_dramrd_ack;
	logic [`RP_WORD_BW-1:0] i_dramrd;
	logic                   o_sramrd_rdy;
	logic                   i_sramrd_ack;
	logic [`RP_WORD_BW-1:0] o_sramrd;
	logic                   o_sramrd_last;

	// expected chunks handed to the monitor
	logic                   exp_valid;
	logic [`RP_ADDR_BW-1:0] exp_start;
	logic [`RP_LEN_BW-1:0]  exp_len;
	int                     mismatch_cnt;
	int                     fail_cnt;
	int                     words_out;
	int                     pending;

	logic [31:0]            vec_mem [VEC_WORDS];
	logic [31:0]            rng_state;
	logic [`RP_ADDR_BW-1:0] mem_addr_q [$];
	int                     mem_due_q [$];
	int                     cycle;
	int                     stall_left;
	int                     n_req;
	int                     total_words;
	int                     tb_fail;
	int                     tb_mismatch;

	read_pipeline read_pipeline_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_req_rdy(i_req_rdy),
		.o_req_ack(o_req_ack),
		.i_req(i_req),
		.i_cfg(cfg),
		.o_dramra_rdy(o_dramra_rdy),
		.i_dramra_ack(i_dramra_ack),
		.o_dramra(o_dramra),
		.i_dramrd_rdy(i_dramrd_rdy),
		.o_dramrd_ack(o_dramrd_ack),
		.i_dramrd(i_dramrd),
		.o_sramrd_rdy(o_sramrd_rdy),
		.i_sramrd_ack(i_sramrd_ack),
		.o_sramrd(o_sramrd),
		.o_sramrd_last(o_sramrd_last)
	);

	read_pipeline_monitor #(
		.MEM_SALT(MEM_SALT)
	) monitor_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_req_rdy(i_req_rdy),
		.i_req_ack(o_req_ack),
		.i_dramra_rdy(o_dramra_rdy),
		.i_dramra_ack(i_dramra_ack),
		.i_dramra(o_dramra),
		.i_sramrd_rdy(o_sramrd_rdy),
		.i_sramrd_ack(i_sramrd_ack),
		.i_sramrd(o_sramrd),
		.i_sramrd_last(o_sramrd_last),
		.i_exp_valid(exp_valid),
		.i_exp_start(exp_start),
		.i_exp_len(exp_len),
		.o_mismatch_cnt(mismatch_cnt),
		.o_fail_cnt(fail_cnt),
		.o_words_out(words_out),
		.o_pending(pending)
	);

	bind read_pipeline read_pipeline_checker checker_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_sramrd_rdy(o_sramrd_rdy),
		.i_sramrd_ack(i_sramrd_ack),
		.i_sramrd(o_sramrd),
		.i_sramrd_last(o_sramrd_last),
		.i_dramra_rdy(o_dramra_rdy),
		.i_dramra_ack(i_dramra_ack),
		.i_dramra(o_dramra),
		.i_alloc(fetch_desc_ack)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// word k of request r in the vectors image
	function automatic logic [31:0] req_word(input int r, input int k);
		return vec_mem[3 * `RP_N_CFG + 1 + 5 * r + k];
	endfunction

	// ======================================================================
	// memory model and output consumer
	// ======================================================================
	// data for address A is A + MEM_SALT and returns in address order
	always @(posedge i_clk) begin
		cycle++;
		if (i_dramrd_rdy && o_dramrd_ack) begin
			void'(mem_addr_q.pop_front());
			void'(mem_due_q.pop_front());
		end
		if (o_dramra_rdy && i_dramra_ack) begin
			rng_state = lcg_next(rng_state);
			mem_addr_q.push_back(o_dramra);
			mem_due_q.push_back(cycle + int'(rng_state[25:24]));
		end
		if (stall_left > 0) begin
			stall_left--;
		end
		#(DRIVE_DELAY);
		rng_state    = lcg_next(rng_state);
		i_dramra_ack = (rng_state[29:28] != 2'b00);
		rng_state    = lcg_next(rng_state);
		i_sramrd_ack = (stall_left == 0) && (rng_state[29:28] != 2'b00);
		if (mem_addr_q.size() > 0 && mem_due_q[0] <= cycle) begin
			i_dramrd_rdy = 1'b1;
			i_dramrd     = mem_addr_q[0] + MEM_SALT;
		end else begin
			i_dramrd_rdy = 1'b0;
			i_dramrd     = '0;
		end
	end

	// ======================================================================
	// stimulus tasks
	// ======================================================================
	task automatic load_vectors();
		logic [31:0] w;
		$readmemh("read_pipeline_vectors.txt", vec_mem);
		for (int c = 0; c < `RP_N_CFG; c++) begin
			w                 = vec_mem[3 * c + 2];
			cfg[c].base       = vec_mem[3 * c];
			cfg[c].row_stride = vec_mem[3 * c + 1];
			cfg[c].len        = w[`RP_LEN_BW-1:0];
		end
		n_req = int'(vec_mem[3 * `RP_N_CFG]);
		if (n_req <= 0 || 3 * `RP_N_CFG + 1 + 5 * n_req > VEC_WORDS) begin
			$display("vectors file holds no usable request count");
			tb_fail++;
			n_req = 0;
		end
		total_words = 0;
		for (int r = 0; r < n_req; r++) begin
			total_words += int'(req_word(r, 4));
		end
	endtask

	task automatic apply_reset();
		i_rst = 1'b0;
		repeat (3) @(posedge i_clk);
		#(DRIVE_DELAY);
		i_rst = 1'b1;
	endtask

	// one expected chunk per cycle while the request inputs stay idle
	task automatic post_expectations();
		logic [31:0] w;
		for (int r = 0; r < n_req; r++) begin
			@(posedge i_clk);
			#(DRIVE_DELAY);
			w         = req_word(r, 4);
			exp_valid = 1'b1;
			exp_start = req_word(r, 3);
			exp_len   = w[`RP_LEN_BW-1:0];
		end
		@(posedge i_clk);
		#(DRIVE_DELAY);
		exp_valid = 1'b0;
	endtask

	// back to back requests while the output is held off for a while
	task automatic send_requests();
		int          wait_cnt;
		logic [31:0] w_cfg;
		logic [31:0] w_row;
		logic [31:0] w_col;
		block_req_t  req;
		stall_left = STALL_CYCLES;
		for (int r = 0; r < n_req && tb_fail == 0; r++) begin
			w_cfg       = req_word(r, 0);
			w_row       = req_word(r, 1);
			w_col       = req_word(r, 2);
			req.cfg_id  = w_cfg[$clog2(`RP_N_CFG)-1:0];
			req.row_ofs = w_row[`RP_OFS_BW-1:0];
			req.col_ofs = w_col[`RP_OFS_BW-1:0];
			i_req       = req;
			i_req_rdy   = 1'b1;
			wait_cnt    = 0;
			@(posedge i_clk);
			while (!o_req_ack && wait_cnt < REQ_TIMEOUT) begin
				@(posedge i_clk);
				wait_cnt++;
			end
			if (!o_req_ack) begin
				$display("%0d ns: request %0d was not accepted within %0d cycles",
					$time, r, REQ_TIMEOUT);
				tb_fail++;
			end
			#(DRIVE_DELAY);
		end
		i_req_rdy = 1'b0;
		i_req     = '0;
	endtask

	task automatic wait_drain();
		int wait_cnt;
		wait_cnt = 0;
		@(negedge i_clk);
		while (pending != 0 && wait_cnt < DRAIN_TIMEOUT) begin
			@(negedge i_clk);
			wait_cnt++;
		end
		if (pending != 0) begin
			$display("%0d ns: pipeline did not drain within %0d cycles, %0d of %0d words out",
				$time, DRAIN_TIMEOUT, words_out, total_words);
			tb_fail++;
		end else begin
			// quiet period to catch stray words
			repeat (20) @(negedge i_clk);
		end
	endtask

	task automatic report();
		int n_assert;
		int n_errors;
		n_assert = read_pipeline_i.checker_i.n_fail;
		if (words_out != total_words) begin
			$display("Mismatch at %0d ns: output word count got %0d expected %0d",
				$time, words_out, total_words);
			tb_mismatch++;
		end
		n_errors = mismatch_cnt + tb_mismatch + fail_cnt + tb_fail + n_assert;
		$display("mismatches %0d, failures %0d, assertion failures %0d, words %0d",
			mismatch_cnt + tb_mismatch, fail_cnt + tb_fail, n_assert, words_out);
		if (n_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	initial begin
		i_clk        = 1'b0;
		i_rst        = 1'b0;
		i_req_rdy    = 1'b0;
		i_req        = '0;
		i_dramra_ack = 1'b0;
		i_dramrd_rdy = 1'b0;
		i_dramrd     = '0;
		i_sramrd_ack = 1'b0;
		exp_valid    = 1'b0;
		exp_start    = '0;
		exp_len      = '0;
		rng_state    = 32'hc0f1;
		cycle        = 0;
		stall_left   = 0;
		tb_fail      = 0;
		tb_mismatch  = 0;
		load_vectors();
		apply_reset();
		post_expectations();
		send_requests();
		if (tb_fail == 0) begin
			wait_drain();
		end
		report();
	end

endmodule
